// ==== logic/clint.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint (
    input  wire               clk,
    input  wire               rst_n_i,
    input  soc_pkg::wb_req_t  wb_req_i,
    output soc_pkg::wb_rsp_t  wb_rsp_o,
    output logic              timer_irq_o
);

    typedef logic [63:0] mtime_t;

    mtime_t          mtime_q;
    mtime_t          mtimecmp_q;
    soc_pkg::data_t  rdata_d;
    soc_pkg::data_t  rdata_q;
    logic            ack_q;
    logic            irq_q;
    logic            strobe;
    logic            wr_en;
    logic [15:0]     ofs;

    assign ofs    = wb_req_i.adr[15:0];
    assign strobe = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = strobe && wb_req_i.we;

    // Register read mux, unknown offsets read zero
    always_comb begin
        case (ofs)
            soc_pkg::MTIMECMP_LO_OFS: rdata_d = mtimecmp_q[31:0];
            soc_pkg::MTIMECMP_HI_OFS: rdata_d = mtimecmp_q[63:32];
            soc_pkg::MTIME_LO_OFS:    rdata_d = mtime_q[31:0];
            soc_pkg::MTIME_HI_OFS:    rdata_d = mtime_q[63:32];
            default:                  rdata_d = '0;
        endcase
    end

    // ==============================
    // Timer and compare registers
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            ack_q      <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            ack_q   <= strobe;
            irq_q   <= (mtime_q >= mtimecmp_q);
            mtime_q <= mtime_q + 64'd1;
            if (wr_en) begin
                case (ofs)
                    soc_pkg::MTIMECMP_LO_OFS: mtimecmp_q[31:0]  <= wb_req_i.dat;
                    soc_pkg::MTIMECMP_HI_OFS: mtimecmp_q[63:32] <= wb_req_i.dat;
                    // Written half replaces the count for this cycle
                    soc_pkg::MTIME_LO_OFS:    mtime_q <= {mtime_q[63:32], wb_req_i.dat};
                    soc_pkg::MTIME_HI_OFS:    mtime_q <= {wb_req_i.dat, mtime_q[31:0]};
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            rdata_q <= rdata_d;
        end
    end

    assign wb_rsp_o    = '{dat: rdata_q, ack: ack_q, err: 1'b0};
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int DMEM_DEPTH = 128
) (
    input  wire               clk,
    input  wire               rst_n_i,
    input  soc_pkg::wb_req_t  wb_req_i,
    output soc_pkg::wb_rsp_t  wb_rsp_o
);

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    soc_pkg::data_t  mem [DMEM_DEPTH];
    soc_pkg::data_t  rdata_q;
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic             strobe;

    // Word index, wraps at the memory size
    assign idx    = wb_req_i.adr[IDX_W+1:2];
    assign strobe = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;
        end
    end

    // Byte-lane writes and registered read
    always_ff @(posedge clk) begin
        if (strobe) begin
            if (wb_req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_req_i.sel[b]) begin
                        mem[idx][b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign wb_rsp_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== logic/gpio_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl #(
    parameter int NUM_GPIO = 24
) (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  soc_pkg::wb_req_t    wb_req_i,
    output soc_pkg::wb_rsp_t    wb_rsp_o,
    input  wire  [NUM_GPIO-1:0] gpio_i,
    output logic [NUM_GPIO-1:0] gpio_o,
    output logic [NUM_GPIO-1:0] gpio_en_o
);

    logic [NUM_GPIO-1:0] out_q;
    logic [NUM_GPIO-1:0] oe_q;
    logic [NUM_GPIO-1:0] sync1_q;
    logic [NUM_GPIO-1:0] sync2_q;
    soc_pkg::data_t      rdata_d;
    soc_pkg::data_t      rdata_q;
    logic                ack_q;
    logic                strobe;
    logic [7:0]          ofs;

    assign ofs    = wb_req_i.adr[7:0];
    assign strobe = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    // Pin input synchroniser
    always_ff @(posedge clk) begin
        sync1_q <= gpio_i;
        sync2_q <= sync1_q;
    end

    // Readback, zero-extended to the bus width
    always_comb begin
        rdata_d = '0;
        case (ofs)
            soc_pkg::GPIO_OUT_OFS: rdata_d[NUM_GPIO-1:0] = out_q;
            soc_pkg::GPIO_OE_OFS:  rdata_d[NUM_GPIO-1:0] = oe_q;
            soc_pkg::GPIO_IN_OFS:  rdata_d[NUM_GPIO-1:0] = sync2_q;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
            oe_q  <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;
            if (strobe && wb_req_i.we) begin
                if (ofs == soc_pkg::GPIO_OUT_OFS) begin
                    out_q <= wb_req_i.dat[NUM_GPIO-1:0];
                end
                if (ofs == soc_pkg::GPIO_OE_OFS) begin
                    oe_q <= wb_req_i.dat[NUM_GPIO-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            rdata_q <= rdata_d;
        end
    end

    assign wb_rsp_o  = '{dat: rdata_q, ack: ack_q, err: 1'b0};
    assign gpio_o    = out_q;
    assign gpio_en_o = oe_q;

endmodule

`default_nettype wire

// ==== logic/mini_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_soc #(
    parameter int DMEM_DEPTH = 128,
    parameter int NUM_GPIO   = 24
) (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  soc_pkg::mem_req_t   proc_req_i,
    output soc_pkg::data_t      proc_rdata_o,
    output logic                proc_ack_o,
    output logic                proc_stall_o,
    input  wire  [NUM_GPIO-1:0] gpio_i,
    output logic [NUM_GPIO-1:0] gpio_o,
    output logic [NUM_GPIO-1:0] gpio_en_o,
    output logic                timer_irq_o
);

    soc_pkg::wb_req_t m_req;
    soc_pkg::wb_rsp_t m_rsp;
    soc_pkg::wb_req_t dmem_req;
    soc_pkg::wb_rsp_t dmem_rsp;
    soc_pkg::wb_req_t clint_req;
    soc_pkg::wb_rsp_t clint_rsp;
    soc_pkg::wb_req_t gpio_req;
    soc_pkg::wb_rsp_t gpio_rsp;

    // ==============================
    // Bus master and decode
    // ==============================
    wb_controller i_wb_controller (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (proc_req_i),
        .wb_req_o (m_req),
        .wb_rsp_i (m_rsp),
        .rdata_o  (proc_rdata_o),
        .ack_o    (proc_ack_o),
        .stall_o  (proc_stall_o)
    );

    wb_intercon i_wb_intercon (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .m_req_i     (m_req),
        .m_rsp_o     (m_rsp),
        .dmem_req_o  (dmem_req),
        .clint_req_o (clint_req),
        .gpio_req_o  (gpio_req),
        .dmem_rsp_i  (dmem_rsp),
        .clint_rsp_i (clint_rsp),
        .gpio_rsp_i  (gpio_rsp)
    );

    // ==============================
    // Slaves
    // ==============================
    data_mem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_data_mem (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_req_i (dmem_req),
        .wb_rsp_o (dmem_rsp)
    );

    clint i_clint (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (clint_req),
        .wb_rsp_o    (clint_rsp),
        .timer_irq_o (timer_irq_o)
    );

    gpio_ctrl #(
        .NUM_GPIO (NUM_GPIO)
    ) i_gpio_ctrl (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (gpio_req),
        .wb_rsp_o  (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_en_o (gpio_en_o)
    );

endmodule

`default_nettype wire

// ==== logic/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // ==============================
    // Bus widths
    // ==============================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_sel_t;

    // RISC-V load/store funct3 encodings
    typedef enum logic [2:0] {
        OP_BYTE   = 3'b000,
        OP_HALF   = 3'b001,
        OP_WORD   = 3'b010,
        OP_BYTE_U = 3'b100,
        OP_HALF_U = 3'b101
    } mem_op_e;

    // Processor data port request
    typedef struct packed {
        addr_t   addr;
        data_t   wdata;
        mem_op_e op;
        logic    read;
        logic    write;
    } mem_req_t;

    // Wishbone master to slave
    typedef struct packed {
        addr_t     adr;
        data_t     dat;
        byte_sel_t sel;
        logic      we;
        logic      cyc;
        logic      stb;
    } wb_req_t;

    // Wishbone slave to master
    typedef struct packed {
        data_t dat;
        logic  ack;
        logic  err;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        SLV_DMEM  = 2'd0,
        SLV_CLINT = 2'd1,
        SLV_GPIO  = 2'd2,
        SLV_NONE  = 2'd3
    } slave_sel_e;

    // ==============================
    // Address map, bits 31..24
    // ==============================
    localparam logic [7:0] DMEM_BASE_HI  = 8'h10;
    localparam logic [7:0] CLINT_BASE_HI = 8'h02;
    localparam logic [7:0] GPIO_BASE_HI  = 8'h20;

    // CLINT register offsets
    localparam logic [15:0] MTIMECMP_LO_OFS = 16'h4000;
    localparam logic [15:0] MTIMECMP_HI_OFS = 16'h4004;
    localparam logic [15:0] MTIME_LO_OFS    = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFS    = 16'hBFFC;

    // GPIO register offsets
    localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [7:0] GPIO_OE_OFS  = 8'h04;
    localparam logic [7:0] GPIO_IN_OFS  = 8'h08;

endpackage

`default_nettype wire

// ==== logic/wb_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_controller (
    input  wire                clk,
    input  wire                rst_n_i,
    input  soc_pkg::mem_req_t  req_i,
    output soc_pkg::wb_req_t   wb_req_o,
    input  soc_pkg::wb_rsp_t   wb_rsp_i,
    output soc_pkg::data_t     rdata_o,
    output logic               ack_o,
    output logic               stall_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } state_e;

    state_e              state_q;
    logic                cyc_q;
    soc_pkg::addr_t      adr_q;
    soc_pkg::data_t      dat_q;
    soc_pkg::byte_sel_t  sel_q;
    logic                we_q;
    soc_pkg::mem_op_e    op_q;
    soc_pkg::data_t      rdata_q;

    soc_pkg::data_t      lane_data;
    soc_pkg::byte_sel_t  lane_sel;
    soc_pkg::data_t      shifted;
    soc_pkg::data_t      load_data;
    logic [7:0]          byte_v;
    logic [15:0]         half_v;
    logic                accept;
    logic                bus_done;

    assign accept   = (state_q == ST_IDLE) && (req_i.read || req_i.write);
    assign bus_done = (state_q == ST_BUSY) && (wb_rsp_i.ack || wb_rsp_i.err);

    // ==============================
    // Store lane placement
    // ==============================
    always_comb begin
        case (req_i.op)
            soc_pkg::OP_BYTE, soc_pkg::OP_BYTE_U: begin
                lane_data = {4{req_i.wdata[7:0]}};
                lane_sel  = soc_pkg::byte_sel_t'(4'b0001 << req_i.addr[1:0]);
            end
            soc_pkg::OP_HALF, soc_pkg::OP_HALF_U: begin
                lane_data = {2{req_i.wdata[15:0]}};
                lane_sel  = req_i.addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_data = req_i.wdata;
                lane_sel  = 4'b1111;
            end
        endcase
    end

    // ==============================
    // Load alignment and extension
    // ==============================
    always_comb begin
        shifted = wb_rsp_i.dat >> {adr_q[1:0], 3'b000};
        byte_v  = shifted[7:0];
        half_v  = adr_q[1] ? wb_rsp_i.dat[31:16] : wb_rsp_i.dat[15:0];
        case (op_q)
            soc_pkg::OP_BYTE:   load_data = {{24{byte_v[7]}}, byte_v};
            soc_pkg::OP_BYTE_U: load_data = {24'h000000, byte_v};
            soc_pkg::OP_HALF:   load_data = {{16{half_v[15]}}, half_v};
            soc_pkg::OP_HALF_U: load_data = {16'h0000, half_v};
            default:            load_data = wb_rsp_i.dat;
        endcase
    end

    // Access FSM, one transfer in flight
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cyc_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_BUSY;
                        cyc_q   <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (bus_done) begin
                        state_q <= ST_DONE;
                        cyc_q   <= 1'b0;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request fields and load result
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= req_i.addr;
            dat_q <= lane_data;
            sel_q <= lane_sel;
            we_q  <= req_i.write;
            op_q  <= req_i.op;
        end
        if (bus_done) begin
            rdata_q <= wb_rsp_i.err ? '0 : load_data;
        end
    end

    assign wb_req_o = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q, cyc: cyc_q, stb: cyc_q};

    assign rdata_o = rdata_q;
    assign ack_o   = (state_q == ST_DONE);
    assign stall_o = (state_q != ST_IDLE);

endmodule

`default_nettype wire

// ==== logic/wb_intercon.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_intercon (
    input  wire               clk,
    input  wire               rst_n_i,
    input  soc_pkg::wb_req_t  m_req_i,
    output soc_pkg::wb_rsp_t  m_rsp_o,
    output soc_pkg::wb_req_t  dmem_req_o,
    output soc_pkg::wb_req_t  clint_req_o,
    output soc_pkg::wb_req_t  gpio_req_o,
    input  soc_pkg::wb_rsp_t  dmem_rsp_i,
    input  soc_pkg::wb_rsp_t  clint_rsp_i,
    input  soc_pkg::wb_rsp_t  gpio_rsp_i
);

    soc_pkg::slave_sel_e slv_sel;
    logic                err_q;

    // Pass a request on with its handshake only when enabled
    function automatic soc_pkg::wb_req_t gate_req(soc_pkg::wb_req_t req, logic en);
        soc_pkg::wb_req_t r;
        r     = req;
        r.cyc = req.cyc & en;
        r.stb = req.stb & en;
        return r;
    endfunction

    // Slave decode from the upper address byte
    always_comb begin
        case (m_req_i.adr[31:24])
            soc_pkg::DMEM_BASE_HI:  slv_sel = soc_pkg::SLV_DMEM;
            soc_pkg::CLINT_BASE_HI: slv_sel = soc_pkg::SLV_CLINT;
            soc_pkg::GPIO_BASE_HI:  slv_sel = soc_pkg::SLV_GPIO;
            default:                slv_sel = soc_pkg::SLV_NONE;
        endcase
    end

    assign dmem_req_o  = gate_req(m_req_i, slv_sel == soc_pkg::SLV_DMEM);
    assign clint_req_o = gate_req(m_req_i, slv_sel == soc_pkg::SLV_CLINT);
    assign gpio_req_o  = gate_req(m_req_i, slv_sel == soc_pkg::SLV_GPIO);

    // Unmapped access, single-cycle error
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_req_i.cyc && m_req_i.stb && (slv_sel == soc_pkg::SLV_NONE) && !err_q;
        end
    end

    // Response return path
    always_comb begin
        case (slv_sel)
            soc_pkg::SLV_DMEM:  m_rsp_o = dmem_rsp_i;
            soc_pkg::SLV_CLINT: m_rsp_o = clint_rsp_i;
            soc_pkg::SLV_GPIO:  m_rsp_o = gpio_rsp_i;
            default:            m_rsp_o = '{dat: soc_pkg::data_t'(0), ack: 1'b0, err: err_q};
        endcase
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the mini_soc testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f verilog.f --top-module tb_mini_soc -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Testbench reported errors, see sim.log"
exit 1

// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Stimulus source, 16-bit Galois LFSR
logic [15:0] lfsr_state = 16'd52569;

// ==============================
// Reference state
// ==============================
soc_pkg::data_t      model_mem [DMEM_DEPTH];
logic [NUM_GPIO-1:0] gpio_out_m;
logic [NUM_GPIO-1:0] gpio_oe_m;

// One LFSR step per bit, first bit ends up as the MSB of the result
function automatic soc_pkg::data_t lfsr_bits(input int n);
    soc_pkg::data_t v;
    logic           b;
    v = '0;
    for (int i = 0; i < n; i++) begin
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        v = {v[30:0], b};
    end
    return v;
endfunction

// Word slot in the memory, wraps every DMEM_DEPTH words
function automatic int dmem_index(input soc_pkg::addr_t a);
    return int'((a >> 2) % DMEM_DEPTH);
endfunction

function automatic soc_pkg::addr_t rand_dmem_addr();
    soc_pkg::data_t r;
    r = lfsr_bits(24);
    return {soc_pkg::DMEM_BASE_HI, r[23:0]};
endfunction

// Moves a mapped upper byte out of the map
function automatic soc_pkg::addr_t unmapped_addr();
    soc_pkg::data_t r;
    logic [7:0]     hi;
    r  = lfsr_bits(32);
    hi = r[31:24];
    if (hi == soc_pkg::DMEM_BASE_HI || hi == soc_pkg::CLINT_BASE_HI ||
        hi == soc_pkg::GPIO_BASE_HI) begin
        hi = hi ^ 8'h40;
    end
    return {hi, r[23:0]};
endfunction

function automatic soc_pkg::addr_t clint_addr(input logic [15:0] ofs);
    return {soc_pkg::CLINT_BASE_HI, 8'h00, ofs};
endfunction

function automatic soc_pkg::addr_t gpio_addr(input logic [7:0] ofs);
    return {soc_pkg::GPIO_BASE_HI, 16'h0000, ofs};
endfunction

// Store merge into the model word
function automatic void model_store(input soc_pkg::addr_t a, input soc_pkg::data_t d,
                                    input soc_pkg::mem_op_e op);
    int idx;
    int lane;
    idx  = dmem_index(a);
    lane = int'(a[1:0]);
    case (op)
        soc_pkg::OP_BYTE, soc_pkg::OP_BYTE_U: model_mem[idx][8*lane +: 8] = d[7:0];
        soc_pkg::OP_HALF, soc_pkg::OP_HALF_U: model_mem[idx][16*(lane/2) +: 16] = d[15:0];
        default: model_mem[idx] = d;
    endcase
endfunction

// Expected load value from the addressed word
function automatic soc_pkg::data_t expected_load(input soc_pkg::data_t word,
                                                 input soc_pkg::addr_t a,
                                                 input soc_pkg::mem_op_e op);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*int'(a[1:0]) +: 8];
    h = word[16*int'(a[1]) +: 16];
    case (op)
        soc_pkg::OP_BYTE:   return 32'(signed'(b));
        soc_pkg::OP_BYTE_U: return 32'(b);
        soc_pkg::OP_HALF:   return 32'(signed'(h));
        soc_pkg::OP_HALF_U: return 32'(h);
        default:            return word;
    endcase
endfunction

`endif

// ==== tests/tb_mini_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mini_soc;

    localparam int DMEM_DEPTH = 128;
    localparam int NUM_GPIO   = 24;

    // Accesses per test
    localparam int WORD_OPS       = 40;
    localparam int SUBWORD_ROUNDS = 24;
    localparam int GPIO_ROUNDS    = 8;
    localparam int UNMAP_ROUNDS   = 6;
    localparam int NUM_ACCESSES   = 2 + DMEM_DEPTH + WORD_OPS + 6 * SUBWORD_ROUNDS
                                  + 5 * GPIO_ROUNDS + 12 + 3 * UNMAP_ROUNDS;
    localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 6 + 200;

    logic                clk;
    logic                rst_n;
    soc_pkg::mem_req_t   proc_req;
    soc_pkg::data_t      proc_rdata;
    logic                proc_ack;
    logic                proc_stall;
    logic [NUM_GPIO-1:0] gpio_in;
    logic [NUM_GPIO-1:0] gpio_out;
    logic [NUM_GPIO-1:0] gpio_en;
    logic                timer_irq;

    int    cycle_cnt;
    int    err_cnt;
    int    test_err_base;
    int    tests_passed;
    int    tests_failed;
    string cur_test;
    int    last_latency;
    logic  last_stall_ok;

    soc_pkg::mem_op_e load_ops [5] = '{soc_pkg::OP_BYTE, soc_pkg::OP_HALF, soc_pkg::OP_WORD,
                                       soc_pkg::OP_BYTE_U, soc_pkg::OP_HALF_U};
    soc_pkg::mem_op_e store_ops [4] = '{soc_pkg::OP_BYTE, soc_pkg::OP_HALF,
                                        soc_pkg::OP_BYTE_U, soc_pkg::OP_HALF_U};

    `include "tb_model.svh"

    mini_soc #(
        .DMEM_DEPTH (DMEM_DEPTH),
        .NUM_GPIO   (NUM_GPIO)
    ) i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .proc_req_i   (proc_req),
        .proc_rdata_o (proc_rdata),
        .proc_ack_o   (proc_ack),
        .proc_stall_o (proc_stall),
        .gpio_i       (gpio_in),
        .gpio_o       (gpio_out),
        .gpio_en_o    (gpio_en),
        .timer_irq_o  (timer_irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // ==============================
    // Checks and reporting
    // ==============================
    task automatic check_value(input string what, input soc_pkg::data_t exp,
                               input soc_pkg::data_t act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_range(input string what, input soc_pkg::data_t lo, input int span,
                               input soc_pkg::data_t act);
        soc_pkg::data_t diff;
        soc_pkg::data_t hi;
        diff = act - lo;
        hi   = lo + soc_pkg::data_t'(span);
        assert (diff <= soc_pkg::data_t'(span)) else begin
            $display("MISMATCH %s %s: expected %08h to %08h, actual %08h",
                     cur_test, what, lo, hi, act);
            err_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR %s: %s", cur_test, what);
            err_cnt++;
        end
    endtask

    task automatic report_test();
        if (err_cnt == test_err_base) begin
            tests_passed++;
            $display("Test %s: PASS", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", cur_test, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // One processor access up to its proc_ack_o
    task automatic bus_access(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                              input soc_pkg::mem_op_e op, input logic wr,
                              output soc_pkg::data_t rdata);
        int   cycles;
        logic stall_ok;
        stall_ok = 1'b1;
        @(negedge clk);
        while (proc_stall) begin
            @(negedge clk);
        end
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        proc_req.op    = op;
        proc_req.write = wr;
        proc_req.read  = !wr;
        @(posedge clk);
        @(negedge clk);
        proc_req.read  = 1'b0;
        proc_req.write = 1'b0;
        cycles = 1;
        while (!proc_ack) begin
            stall_ok = stall_ok && proc_stall;
            @(negedge clk);
            cycles++;
        end
        stall_ok      = stall_ok && proc_stall;
        rdata         = proc_rdata;
        last_latency  = cycles;
        last_stall_ok = stall_ok;
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic reset_and_latency();
        soc_pkg::addr_t a;
        soc_pkg::data_t d;
        soc_pkg::data_t rd;
        cur_test = "reset_latency";
        check_value("proc_ack_o", '0, 32'(proc_ack));
        check_value("proc_stall_o", '0, 32'(proc_stall));
        check_value("cyc", '0, 32'(i_dut.m_req.cyc));
        check_value("stb", '0, 32'(i_dut.m_req.stb));
        check_value("gpio_o", '0, 32'(gpio_out));
        check_value("gpio_en_o", '0, 32'(gpio_en));
        check_value("timer_irq_o", '0, 32'(timer_irq));
        a = rand_dmem_addr();
        d = lfsr_bits(32);
        bus_access(a, d, soc_pkg::OP_WORD, 1'b1, rd);
        model_store(a, d, soc_pkg::OP_WORD);
        check_value("write latency", 32'd3, last_latency);
        check_true(last_stall_ok, "proc_stall_o went low before the write acknowledge");
        @(negedge clk);
        check_value("ack after pulse", '0, 32'(proc_ack));
        bus_access(a, '0, soc_pkg::OP_WORD, 1'b0, rd);
        check_value("read latency", 32'd3, last_latency);
        check_true(last_stall_ok, "proc_stall_o went low before the read acknowledge");
        check_value("read data", model_mem[dmem_index(a)], rd);
        report_test();
    endtask

    task automatic word_storage();
        soc_pkg::addr_t a;
        soc_pkg::data_t d;
        soc_pkg::data_t rd;
        cur_test = "word_storage";
        // Fill all words
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            a = {soc_pkg::DMEM_BASE_HI, 24'(i * 4)};
            d = lfsr_bits(32);
            bus_access(a, d, soc_pkg::OP_WORD, 1'b1, rd);
            model_store(a, d, soc_pkg::OP_WORD);
        end
        for (int i = 0; i < WORD_OPS; i++) begin
            a = rand_dmem_addr();
            if (lfsr_bits(1) == 32'd1) begin
                d = lfsr_bits(32);
                bus_access(a, d, soc_pkg::OP_WORD, 1'b1, rd);
                model_store(a, d, soc_pkg::OP_WORD);
            end else begin
                bus_access(a, '0, soc_pkg::OP_WORD, 1'b0, rd);
                check_value("word read", model_mem[dmem_index(a)], rd);
            end
        end
        report_test();
    endtask

    task automatic subword_access();
        soc_pkg::addr_t   a;
        soc_pkg::addr_t   la;
        soc_pkg::data_t   d;
        soc_pkg::data_t   rd;
        soc_pkg::mem_op_e op;
        cur_test = "subword_access";
        for (int i = 0; i < SUBWORD_ROUNDS; i++) begin
            a  = rand_dmem_addr();
            d  = lfsr_bits(32);
            op = store_ops[int'(lfsr_bits(2))];
            bus_access(a, d, op, 1'b1, rd);
            model_store(a, d, op);
            // Every load kind from the same word
            for (int k = 0; k < 5; k++) begin
                la = {a[31:2], 2'b00} | lfsr_bits(2);
                bus_access(la, '0, load_ops[k], 1'b0, rd);
                check_value(load_ops[k].name(),
                            expected_load(model_mem[dmem_index(la)], la, load_ops[k]), rd);
            end
        end
        report_test();
    endtask

    task automatic gpio_regs();
        soc_pkg::data_t r;
        soc_pkg::data_t rd;
        cur_test = "gpio";
        for (int i = 0; i < GPIO_ROUNDS; i++) begin
            r = lfsr_bits(32);
            gpio_out_m = r[NUM_GPIO-1:0];
            bus_access(gpio_addr(soc_pkg::GPIO_OUT_OFS), r, soc_pkg::OP_WORD, 1'b1, rd);
            r = lfsr_bits(32);
            gpio_oe_m = r[NUM_GPIO-1:0];
            bus_access(gpio_addr(soc_pkg::GPIO_OE_OFS), r, soc_pkg::OP_WORD, 1'b1, rd);
            bus_access(gpio_addr(soc_pkg::GPIO_OUT_OFS), '0, soc_pkg::OP_WORD, 1'b0, rd);
            check_value("OUT readback", 32'(gpio_out_m), rd);
            bus_access(gpio_addr(soc_pkg::GPIO_OE_OFS), '0, soc_pkg::OP_WORD, 1'b0, rd);
            check_value("OE readback", 32'(gpio_oe_m), rd);
            check_value("gpio_o pins", 32'(gpio_out_m), 32'(gpio_out));
            check_value("gpio_en_o pins", 32'(gpio_oe_m), 32'(gpio_en));
            r = lfsr_bits(NUM_GPIO);
            @(negedge clk);
            gpio_in = r[NUM_GPIO-1:0];
            bus_access(gpio_addr(soc_pkg::GPIO_IN_OFS), '0, soc_pkg::OP_WORD, 1'b0, rd);
            check_value("IN readback", 32'(r[NUM_GPIO-1:0]), rd);
        end
        report_test();
    endtask

    task automatic timer_regs();
        soc_pkg::data_t lo;
        soc_pkg::data_t hi;
        soc_pkg::data_t v;
        soc_pkg::data_t rd;
        cur_test = "timer";
        lo = lfsr_bits(32);
        hi = lfsr_bits(32);
        bus_access(clint_addr(soc_pkg::MTIMECMP_LO_OFS), lo, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIMECMP_HI_OFS), hi, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIMECMP_LO_OFS), '0, soc_pkg::OP_WORD, 1'b0, rd);
        check_value("mtimecmp low", lo, rd);
        bus_access(clint_addr(soc_pkg::MTIMECMP_HI_OFS), '0, soc_pkg::OP_WORD, 1'b0, rd);
        check_value("mtimecmp high", hi, rd);
        // Time near zero and compare above 2^32
        bus_access(clint_addr(soc_pkg::MTIME_HI_OFS), '0, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIME_LO_OFS), '0, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIMECMP_HI_OFS), 32'd1, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIMECMP_LO_OFS), lo, soc_pkg::OP_WORD, 1'b1, rd);
        check_value("irq below compare", '0, 32'(timer_irq));
        bus_access(clint_addr(soc_pkg::MTIMECMP_HI_OFS), '0, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIMECMP_LO_OFS), '0, soc_pkg::OP_WORD, 1'b1, rd);
        check_value("irq at zero compare", 32'd1, 32'(timer_irq));
        v = lfsr_bits(32);
        bus_access(clint_addr(soc_pkg::MTIME_LO_OFS), v, soc_pkg::OP_WORD, 1'b1, rd);
        bus_access(clint_addr(soc_pkg::MTIME_LO_OFS), '0, soc_pkg::OP_WORD, 1'b0, rd);
        check_range("mtime low", v, 20, rd);
        report_test();
    endtask

    task automatic unmapped_access();
        soc_pkg::addr_t a;
        soc_pkg::addr_t alias_a;
        soc_pkg::data_t rd;
        cur_test = "unmapped";
        for (int i = 0; i < UNMAP_ROUNDS; i++) begin
            a = unmapped_addr();
            bus_access(a, '0, soc_pkg::OP_WORD, 1'b0, rd);
            check_value("unmapped read", '0, rd);
            bus_access(a, lfsr_bits(32), soc_pkg::OP_WORD, 1'b1, rd);
            alias_a = {soc_pkg::DMEM_BASE_HI, a[23:0]};
            bus_access(alias_a, '0, soc_pkg::OP_WORD, 1'b0, rd);
            check_value("memory after unmapped write", model_mem[dmem_index(alias_a)], rd);
        end
        report_test();
    endtask

    // ==============================
    // Sequence
    // ==============================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        proc_req      = '0;
        gpio_in       = '0;
        cycle_cnt     = 0;
        err_cnt       = 0;
        test_err_base = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        gpio_out_m    = '0;
        gpio_oe_m     = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_and_latency();
        word_storage();
        subword_access();
        gpio_regs();
        timer_regs();
        unmapped_access();
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
logic/soc_pkg.sv
logic/wb_controller.sv
logic/wb_intercon.sv
logic/data_mem.sv
logic/clint.sv
logic/gpio_ctrl.sv
logic/mini_soc.sv
tests/tb_mini_soc.sv
